// ==== verilog.f ====
hdl/posit_pkg.sv
hdl/posit_decode.sv
hdl/posit_frac_mult.sv
hdl/posit_regime_prep.sv
hdl/posit_encode.sv
hdl/posit_mult.sv
verification/tb_clock.sv
verification/posit_mult_assertions.sv
verification/posit_mult_tb.sv

// ==== Makefile ====
# Verilator build and run for the posit(32,3) multiplier testbench

TOP = posit_mult_tb
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): verilog.f hdl/*.sv verification/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f

# The simulator's exit status is ignored here; the log decides the result
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "STATUS: PASS" $(LOG)

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir $(LOG)

// ==== verification/posit_mult_tb.sv ====
// ----------------------------------------------------------
// Testbench for the posit(32,3) multiplier, run as top
// Directed, random and streaming products against a model
// ----------------------------------------------------------
`timescale 1ns/1ps

module posit_mult_tb;
    import posit_pkg::*;

    localparam int PERIOD_NS    = 20;
    localparam int RESET_CYCLES = 16;
    localparam int LATENCY      = 4;
    localparam int N_RANDOM     = 3000;    // Up to two cycles each, with bubbles
    localparam int N_BURST      = 2000;    // Back to back
    localparam int N_SPECIAL    = 4 + 8 * 7;
    localparam int N_SAT        = 6;
    localparam int F0           = NBITS - 3 - ES;   // Fraction bits of a posit in [1,2)
    localparam int N_ROUND      = F0 * 3;
    localparam int MAX_SC       = (NBITS - 2) * (1 << ES);  // Scale of maxpos
    localparam int N_CYCLES     = RESET_CYCLES + 4 + 16 + N_SPECIAL + N_SAT + N_ROUND
                                  + 2 * N_RANDOM + N_BURST + 16;
    localparam int WATCHDOG_NS  = (N_CYCLES + 50) * PERIOD_NS;

    localparam logic [NBITS-1:0] NAR    = 32'h8000_0000;
    localparam logic [NBITS-1:0] ONE    = 32'h4000_0000;
    localparam logic [NBITS-1:0] M_ONE  = 32'hC000_0000;
    localparam logic [NBITS-1:0] MAXPOS = 32'h7FFF_FFFF;
    localparam logic [NBITS-1:0] MINPOS = 32'h0000_0001;
    localparam logic [15:0]      GAP_PATTERN = 16'b1101_0011_1000_1011;

    logic             clk;
    logic             rst_n;
    logic             start;
    logic [NBITS-1:0] in1;
    logic [NBITS-1:0] in2;
    logic [NBITS-1:0] result;
    logic             inf;
    logic             zero;
    logic             done;

    logic [NBITS-1:0] exp_q[$];     // Expected products, oldest first
    int               stamp_q[$];   // Cycle of each launch
    logic [NBITS-1:0] exp_val;
    int               stamp;
    int               cycle = 0;
    int               n_start = 0;
    int               n_done = 0;
    int               seed;

    tb_clock #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) i_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    posit_mult i_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .in1    (in1),
        .in2    (in2),
        .result (result),
        .inf    (inf),
        .zero   (zero),
        .done   (done)
    );

    // Sign-free decode, value = sig * 2^(scale - FBITS)
    function automatic void decode_ref(input logic [NBITS-1:0] p, output int scale,
                                       output logic [63:0] sig);
        logic [NBITS-1:0] m;
        logic [63:0]      f;
        int               i;
        int               run;
        int               k;
        int               e;
        int               nf;
        m   = p[NBITS-1] ? -p : p;
        run = 0;
        i   = NBITS - 2;
        while (i >= 0 && m[i] == m[NBITS-2])
        begin
            run++;
            i--;
        end
        k = m[NBITS-2] ? run - 1 : -run;
        i--;                                   // Skip terminator
        e = 0;
        for (int j = 0; j < ES; j++)
        begin
            e = e * 2;
            if (i >= 0)
                e = e + int'(m[i]);            // Cut-off exponent bits count as zero
            i--;
        end
        f  = '0;
        nf = 0;
        while (i >= 0)
        begin
            f = {f[62:0], m[i]};
            nf++;
            i--;
        end
        scale = k * (1 << ES) + e;
        sig   = (64'd1 << FBITS) | (f << (FBITS - nf));
    endfunction

    // Exact product, then round to nearest even on the encoding with saturation
    function automatic logic [NBITS-1:0] posit_mul_ref(input logic [NBITS-1:0] a,
                                                       input logic [NBITS-1:0] b);
        int               sa;
        int               sb;
        int               sc;
        int               k;
        int               e;
        int               pos;
        logic [63:0]      ma;
        logic [63:0]      mb;
        logic [63:0]      prod;
        logic [2*FBITS:0] frac;
        logic [127:0]     str;                 // Unbounded magnitude encoding, MSB first
        logic [NBITS-2:0] kept;
        logic             rnd;
        logic             sticky;
        if (a == NAR || b == NAR)
            return NAR;
        if (a == '0 || b == '0)
            return '0;
        decode_ref(a, sa, ma);
        decode_ref(b, sb, mb);
        prod = ma * mb;                        // Exact, 2*FBITS fraction bits
        sc   = sa + sb;
        if (prod[2*FBITS+1])
        begin
            sc   = sc + 1;
            frac = prod[2*FBITS:0];
        end
        else
            frac = {prod[2*FBITS-1:0], 1'b0};
        if (sc > MAX_SC)
            kept = MAXPOS[NBITS-2:0];
        else if (sc < -MAX_SC)
            kept = MINPOS[NBITS-2:0];
        else
        begin
            k   = sc >>> ES;
            e   = sc - k * (1 << ES);
            str = '0;
            pos = 127;
            if (k >= 0)
            begin
                for (int j = 0; j <= k; j++)
                begin
                    str[pos] = 1'b1;
                    pos--;
                end
                pos--;                         // Zero terminator
            end
            else
            begin
                pos      = pos + k;            // -k zeros
                str[pos] = 1'b1;
                pos--;
            end
            for (int j = ES - 1; j >= 0; j--)
            begin
                str[pos] = e[j];
                pos--;
            end
            str[pos -: 2*FBITS+1] = frac;
            kept   = str[127 -: NBITS-1];
            rnd    = str[128-NBITS];
            sticky = |str[127-NBITS:0];
            if (rnd && (kept[0] || sticky))
                kept = kept + (NBITS-1)'(1);
        end
        return (a[NBITS-1] ^ b[NBITS-1]) ? -{1'b0, kept} : {1'b0, kept};
    endfunction

    task automatic check_posit(input string name, input logic [NBITS-1:0] got,
                               input logic [NBITS-1:0] expected);
        if (got !== expected)
        begin
            $display("[FAIL] %s: got 0x%h expected 0x%h", name, got, expected);
            $display("STATUS: FAIL");
            $fatal(1, "Posit value mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected)
        begin
            $display("[FAIL] %s: got 0x%h expected 0x%h", name, got, expected);
            $display("STATUS: FAIL");
            $fatal(1, "Flag mismatch");
        end
    endtask

    task automatic check_latency(input int cycles);
        if (cycles != LATENCY)
        begin
            $display("done arrived %0d cycles after its start instead of %0d", cycles, LATENCY);
            $display("STATUS: FAIL");
            $fatal(1, "Latency error");
        end
    endtask

    task automatic launch(input logic [NBITS-1:0] a, input logic [NBITS-1:0] b,
                          input logic [NBITS-1:0] expected);
        @(negedge clk);
        start = 1'b1;
        in1   = a;
        in2   = b;
        exp_q.push_back(expected);
        stamp_q.push_back(cycle);              // Sampled by the next rising edge
        n_start++;
    endtask

    task automatic idle();
        @(negedge clk);
        start = 1'b0;
        in1   = '0;
        in2   = '0;
    endtask

    // Wide spread of scales, reaches the saturation region too
    function automatic logic [NBITS-1:0] spread_operand();
        logic [NBITS-1:0] r;
        int               sh;
        r  = $random(seed);
        sh = $random(seed) & 31;
        return {r[NBITS-1], r[NBITS-2:0] >> sh};
    endfunction

    task automatic run_gaps();
        logic [NBITS-1:0] a;
        logic [NBITS-1:0] b;
        for (int i = 15; i >= 0; i--)
        begin
            a = $random(seed);
            b = $random(seed);
            if (GAP_PATTERN[i])
                launch(a, b, posit_mul_ref(a, b));
            else
                idle();
        end
    endtask

    task automatic run_special();
        logic [NBITS-1:0] x;
        launch(NAR, '0, NAR);
        launch('0, NAR, NAR);
        launch('0, '0, '0);
        launch(NAR, NAR, NAR);
        for (int i = 0; i < 8; i++)
        begin
            x = $random(seed);
            if (x == '0 || x == NAR)
                x = ONE;
            launch('0, x, '0);
            launch(x, '0, '0);
            launch(NAR, x, NAR);
            launch(x, NAR, NAR);
            launch(ONE, x, x);
            launch(x, ONE, x);
            launch(M_ONE, x, -x);              // Negation is the two's complement
        end
    endtask

    task automatic run_saturation();
        launch(MAXPOS, MAXPOS, MAXPOS);
        launch(MINPOS, MINPOS, MINPOS);
        launch(-MAXPOS, MAXPOS, -MAXPOS);
        launch(-MAXPOS, -MAXPOS, MAXPOS);
        launch(-MINPOS, MINPOS, -MINPOS);
        launch(-MINPOS, -MINPOS, MINPOS);
    endtask

    // (1 + 2^j/2^F0) * (1 + (2^(F0-1-j)+d)/2^F0), cross term lands on the round bit
    // d = 0 is an exact tie, d = +1 just above, d = -1 just below
    task automatic run_rounding();
        logic [NBITS-1:0] a;
        logic [NBITS-1:0] b;
        for (int j = 0; j < F0; j++)
        begin
            a = ONE | (NBITS'(1) << j);
            if (j % 2 == 1)
                a = -a;                        // Cover negative products too
            for (int d = -1; d <= 1; d++)
            begin
                b = ONE | NBITS'((1 << (F0 - 1 - j)) + d);
                launch(a, b, posit_mul_ref(a, b));
            end
        end
    endtask

    task automatic run_random(input int count, input bit back_to_back);
        logic [NBITS-1:0] a;
        logic [NBITS-1:0] b;
        for (int i = 0; i < count; i++)
        begin
            if (back_to_back)
            begin
                a = spread_operand();
                b = spread_operand();
            end
            else
            begin
                a = $random(seed);
                b = $random(seed);
            end
            launch(a, b, posit_mul_ref(a, b));
            if (!back_to_back && (($random(seed) & 3) == 0))
                idle();                        // Bubble
        end
    endtask

    always @(posedge clk)
        cycle <= cycle + 1;

    // Outputs are sampled mid-cycle
    always @(negedge clk)
    begin
        if (done)
        begin
            if (exp_q.size() == 0)
            begin
                $display("done pulse with no product pending at cycle %0d", cycle);
                $display("STATUS: FAIL");
                $fatal(1, "Unexpected done");
            end
            else
            begin
                exp_val = exp_q.pop_front();
                stamp   = stamp_q.pop_front();
                n_done++;
                check_latency(cycle - stamp);
                check_posit("result", result, exp_val);
                check_flag("inf", inf, exp_val == NAR);
                check_flag("zero", zero, exp_val == '0);
            end
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, run not finished after %0d ns", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $fatal(1, "Timeout");
    end

    initial
    begin
        start = 1'b0;
        in1   = '0;
        in2   = '0;
        seed  = 17494;
        @(posedge rst_n);
        repeat (4) @(negedge clk);             // Any done here has no pending product
        run_gaps();
        run_special();
        run_saturation();
        run_rounding();
        run_random(N_RANDOM, 1'b0);
        run_random(N_BURST, 1'b1);
        idle();
        // Last product is due LATENCY cycles after its start
        for (int i = 0; i < LATENCY + 4 && exp_q.size() != 0; i++)
            @(negedge clk);
        repeat (8) @(negedge clk);             // Room for stray done pulses
        if (exp_q.size() != 0 || n_done != n_start)
        begin
            $display("Run ended with %0d starts and %0d done pulses", n_start, n_done);
            $display("STATUS: FAIL");
            $fatal(1, "Count mismatch");
        end
        else
        begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

// ==== verification/posit_mult_assertions.sv ====
// ----------------------------------------------------------
// Pipeline timing and flag encoding checks for posit_mult
// Attached to every posit_mult instance by the bind below
// ----------------------------------------------------------
`timescale 1ns/1ps

module posit_mult_assertions (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        start,
    input logic                        done,
    input logic                        inf,
    input logic                        zero,
    input logic [posit_pkg::NBITS-1:0] result
);
    import posit_pkg::*;

    localparam logic [NBITS-1:0] NAR = {1'b1, {NBITS-1{1'b0}}};   // Sign-only pattern

    done_low_in_reset: assert property (@(posedge clk) !rst_n |-> !done)
        else $error("done high while in reset");

    // Four register stages between start and done
    done_follows_start: assert property (@(posedge clk) disable iff (!rst_n)
        done == $past(start, 4))
        else $error("done does not match start four cycles earlier");

    flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> !(inf && zero))
        else $error("inf and zero high together");

    zero_pattern: assert property (@(posedge clk) disable iff (!rst_n)
        (done && zero) |-> (result == '0))
        else $error("zero flag with a nonzero result");

    nar_pattern: assert property (@(posedge clk) disable iff (!rst_n)
        (done && inf) |-> (result == NAR))
        else $error("inf flag without the NaR pattern");

endmodule

bind posit_mult posit_mult_assertions i_assertions (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (start),
    .done   (done),
    .inf    (inf),
    .zero   (zero),
    .result (result)
);

// ==== verification/tb_clock.sv ====
// ----------------------------------------------------------
// Testbench clock and reset source
// Free-running clk, rst_n held low for RESET_CYCLES cycles
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;   // 50% duty
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;                          // Released mid-cycle, clear of the active edge
    end

endmodule

// ==== hdl/posit_mult.sv ====
// ----------------------------------------------------------
// Posit(32,3) multiplier top, four register stages
// Pulse start with in1/in2, done follows four cycles later
// ----------------------------------------------------------
`timescale 1ns/1ps

module posit_mult (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic [posit_pkg::NBITS-1:0] in1,
    input  logic [posit_pkg::NBITS-1:0] in2,
    output logic [posit_pkg::NBITS-1:0] result,
    output logic                        inf,
    output logic                        zero,
    output logic                        done
);
    import posit_pkg::*;

    localparam int NSTAGES = 4;

    logic [NSTAGES-1:0] valid;          // Start bit travelling with the data

    // Stage 0, raw operands and their decoded form
    logic [NBITS-1:0] r0_in1;
    logic [NBITS-1:0] r0_in2;
    posit_value_t     r0_a;
    posit_value_t     r0_b;

    // Stage 1, decoded operands and their product
    posit_value_t     r1_a;
    posit_value_t     r1_b;
    posit_product_t   r1_prod;

    // Stage 2
    posit_product_t   r2_prod;
    posit_pack_t      r2_pack;

    // Stage 3, feeds the encoder and the outputs
    posit_product_t   r3_prod;
    posit_pack_t      r3_pack;

    // Valid chain, start moves one stage per clock toward done
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            valid <= '0;
        else
            valid <= {valid[NSTAGES-2:0], start};
    end

    assign done = valid[NSTAGES-1];

    // Payload pipeline, no stall so every stage loads each cycle
    always_ff @(posedge clk)
    begin
        r0_in1  <= in1;
        r0_in2  <= in2;
        r1_a    <= r0_a;
        r1_b    <= r0_b;
        r2_prod <= r1_prod;
        r3_prod <= r2_prod;     // Sign, flags and scale still needed at the end
        r3_pack <= r2_pack;
    end

    posit_decode i_decode_a (
        .in    (r0_in1),
        .value (r0_a)
    );

    posit_decode i_decode_b (
        .in    (r0_in2),
        .value (r0_b)
    );

    posit_frac_mult i_frac_mult (
        .a       (r1_a),
        .b       (r1_b),
        .product (r1_prod)
    );

    posit_regime_prep i_regime_prep (
        .product (r2_prod),
        .pack    (r2_pack)
    );

    posit_encode i_encode (
        .product (r3_prod),
        .pack    (r3_pack),
        .result  (result),
        .inf     (inf),
        .zero    (zero)
    );

endmodule

// ==== hdl/posit_encode.sv ====
// ----------------------------------------------------------
// Final posit assembly: regime shift, clamp, round to
// nearest even, sign and the zero/NaR special cases
// ----------------------------------------------------------
`timescale 1ns/1ps

module posit_encode (
    input  posit_pkg::posit_product_t   product,
    input  posit_pkg::posit_pack_t      pack,
    output logic [posit_pkg::NBITS-1:0] result,
    output logic                        inf,
    output logic                        zero
);
    import posit_pkg::*;

    logic [2*NBITS-1:0] shifted;    // Word after regime alignment
    logic [NBITS-2:0]   mag;        // Truncated magnitude, no sign
    logic               proj_hi;    // Above maxpos
    logic               proj_lo;    // Below minpos
    logic [NBITS-2:0]   clamped;
    logic               round_up;
    logic [NBITS-2:0]   rounded;
    logic [NBITS-2:0]   signed_mag;
    logic               special;    // Zero or NaR wins over the datapath

    assign shifted = pack.regime_exp_frac >> pack.regime_shift;
    assign mag     = shifted[NBITS-1:1];

    // Inward projection, the product never turns into zero or NaR
    assign proj_hi = (product.scale > MAX_SCALE);
    assign proj_lo = (product.scale < -MAX_SCALE);

    always_comb
    begin
        if (proj_hi)
            clamped = {NBITS-1{1'b1}};                 // maxpos
        else if (proj_lo)
            clamped = {{NBITS-2{1'b0}}, 1'b1};         // minpos
        else
            clamped = mag;
    end

    // Round up above half, or on a tie when the last kept bit is odd
    // Clamped values are final and skip rounding
    assign round_up = ~(proj_hi | proj_lo) & pack.after & (mag[0] | pack.sticky);
    assign rounded  = clamped + {{NBITS-2{1'b0}}, round_up};

    // Negative posits are the two's complement of the positive pattern
    assign signed_mag = product.sign ? -rounded : rounded;

    assign special = product.zero | product.nar;

    always_comb
    begin
        if (special)
            result = {product.nar, {NBITS-1{1'b0}}};   // 0x80000000 or 0
        else
            result = {product.sign, signed_mag};
    end

    assign inf  = product.nar;
    assign zero = product.zero & ~product.nar;  // NaR x 0 reports NaR only

endmodule

// ==== hdl/posit_regime_prep.sv ====
// ----------------------------------------------------------
// Builds the unshifted regime/exponent/fraction word plus
// regime shift, round and sticky bits for the final stage
// ----------------------------------------------------------
`timescale 1ns/1ps

module posit_regime_prep (
    input  posit_pkg::posit_product_t product,
    output posit_pkg::posit_pack_t    pack
);
    import posit_pkg::*;

    // Terminator, exponent and full product fraction in one vector
    localparam int EXT_W = 1 + ES + MBITS;

    logic              neg_scale;     // Scale below zero, regime of zeros
    logic [6:0]        k;             // Regime, scale >>> ES
    logic [ES-1:0]     exp_bits;
    logic [6:0]        shift;
    logic [EXT_W-1:0]  ext;
    logic [4:0]        lo_shift;      // Brings the first dropped bit to the top of ext
    logic [EXT_W-1:0]  dropped;
    logic              after;
    logic              sticky;
    logic [FHBITS-1:0] frac_trunc;    // Fraction bits kept in the word

    assign neg_scale = product.scale[SBITS-1];
    assign k         = product.scale[SBITS-1:ES];
    assign exp_bits  = product.scale[ES-1:0];   // Low bits are the exponent for either sign

    // k >= 0 needs k+1 ones before the terminator, k < 0 needs -k zeros
    assign shift = neg_scale ? (7'd0 - k) : (k + 7'd1);

    // After the right shift, word bit j lands in result bit j-shift
    // ext bit 28+j mirrors word bit j, so the first dropped bit is ext[28+shift]
    assign ext = {neg_scale, exp_bits, product.fraction};

    // Shifts past the word width only occur with inward projection
    assign lo_shift = (shift > 7'(NBITS - 1)) ? 5'd0 : 5'(7'(NBITS - 1) - shift);
    assign dropped  = ext << lo_shift;
    assign after    = dropped[EXT_W-1];
    assign sticky   = |dropped[EXT_W-2:0];      // Includes exponent bits when they fall off

    // Low fraction bit carries the sticky information
    assign frac_trunc = {product.fraction[MBITS-1 -: FBITS],
                         product.fraction[MBITS-1-FBITS] | sticky};

    always_comb
    begin
        pack.regime_exp_frac = {{NBITS{~neg_scale}},   // Regime run, trimmed by the shift
                                neg_scale,             // Terminator
                                exp_bits,
                                frac_trunc};
        pack.regime_shift    = shift;
        pack.after           = after;
        pack.sticky          = sticky;
    end

endmodule

// ==== hdl/posit_frac_mult.sv ====
// ----------------------------------------------------------
// Fraction multiply and scale sum, combinational
// Output fraction is normalized with the hidden bit dropped
// ----------------------------------------------------------
`timescale 1ns/1ps

module posit_frac_mult (
    input  posit_pkg::posit_value_t   a,
    input  posit_pkg::posit_value_t   b,
    output posit_pkg::posit_product_t product
);
    import posit_pkg::*;

    logic [FHBITS-1:0]       frac_a;     // 1.f of operand a
    logic [FHBITS-1:0]       frac_b;     // 1.f of operand b
    logic [MBITS-1:0]        raw;        // Product in [1,4), two integer bits
    logic signed [SBITS-1:0] scale_sum;

    assign frac_a = {1'b1, a.fraction};     // Hidden bit back
    assign frac_b = {1'b1, b.fraction};
    assign raw    = frac_a * frac_b;        // Unsigned, full width
    assign scale_sum = a.scale + b.scale;   // Fits SBITS for every legal operand pair

    always_comb
    begin
        product.sign = a.sign ^ b.sign;
        product.zero = a.zero | b.zero;
        product.nar  = a.nar | b.nar;

        if (raw[MBITS-1])
        begin
            // Product >= 2, radix point moves one place
            product.scale    = scale_sum + SBITS'(1);
            product.fraction = raw << 1;
        end
        else
        begin
            // Product in [1,2), hidden bit sits one below the top
            product.scale    = scale_sum;
            product.fraction = raw << 2;
        end
    end

endmodule

// ==== hdl/posit_decode.sv ====
// ----------------------------------------------------------
// Posit field extraction, combinational
// Gives sign, special flags, signed scale and bare fraction
// ----------------------------------------------------------
`timescale 1ns/1ps

module posit_decode (
    input  logic [posit_pkg::NBITS-1:0] in,
    output posit_pkg::posit_value_t     value
);
    import posit_pkg::*;

    logic [NBITS-1:0]  mag;       // Absolute value
    logic [NBITS-2:0]  body;      // Everything after the sign
    logic              reg_bit;   // Polarity of the regime run
    logic [5:0]        run_len;   // Leading run length, up to 31
    logic              run_end;   // Run already broken while scanning
    logic [5:0]        skip;      // Run plus terminator
    logic [NBITS-2:0]  rest;      // Exponent and fraction, left aligned
    logic [6:0]        k;         // Regime value, two's complement
    logic [ES-1:0]     exp_bits;

    assign mag     = in[NBITS-1] ? -in : in;   // Negative posits decode from their negation
    assign body    = mag[NBITS-2:0];
    assign reg_bit = body[NBITS-2];

    // Leading-run detector
    // Counts how many bits from the top match the first regime bit
    always_comb
    begin
        run_len = '0;
        run_end = 1'b0;
        for (int i = NBITS - 2; i >= 0; i--)
        begin
            if (!run_end && (body[i] == reg_bit))
                run_len = run_len + 6'd1;
            else
                run_end = 1'b1;                // First opposite bit ends the run
        end
    end

    // Run of ones gives k = len-1, run of zeros gives k = -len
    assign k = reg_bit ? ({1'b0, run_len} - 7'd1) : (7'd0 - {1'b0, run_len});

    // Drop the regime and its terminator, exponent then sits on top
    assign skip     = run_len + 6'd1;
    assign rest     = body << skip;            // Shift of 32 clears it, maxpos/minpos case
    assign exp_bits = rest[NBITS-2 -: ES];     // Missing exponent bits read as zero

    always_comb
    begin
        value.sign     = in[NBITS-1];
        value.zero     = (in == '0);
        value.nar      = (in == {1'b1, {NBITS-1{1'b0}}});
        value.scale    = {k, exp_bits};        // k*2^ES + e, exponent is never negative
        value.fraction = rest[NBITS-2-ES -: FBITS];
    end

endmodule

// ==== hdl/posit_pkg.sv ====
// ----------------------------------------------------------
// Posit(32,3) configuration and the bundles passed between
// the multiplier stages; imported by every RTL module
// ----------------------------------------------------------
package posit_pkg;

    // Posit configuration, fixed for this datapath
    localparam int NBITS  = 32;                 // Posit width
    localparam int ES     = 3;                  // Exponent field width
    localparam int FBITS  = NBITS - ES - 2;     // Fraction without hidden bit
    localparam int FHBITS = FBITS + 1;          // Fraction with hidden bit
    localparam int MBITS  = 2 * FHBITS;         // Raw fraction product width
    localparam int SBITS  = 10;                 // Signed scale, regime*8 + exponent

    // Scale of maxpos, useed^(NBITS-2) = 2^240
    // Anything beyond this is projected back onto maxpos/minpos
    localparam logic signed [SBITS-1:0] MAX_SCALE = SBITS'((NBITS - 2) << ES);

    // One decoded operand
    typedef struct packed {
        logic                    sign;      // Sign of the original posit
        logic                    zero;      // All-zero pattern
        logic                    nar;       // Sign-only pattern, Not a Real
        logic signed [SBITS-1:0] scale;     // Regime and exponent combined
        logic [FBITS-1:0]        fraction;  // Hidden bit removed
    } posit_value_t;

    // Normalized product of two operands
    typedef struct packed {
        logic                    sign;
        logic                    zero;
        logic                    nar;
        logic signed [SBITS-1:0] scale;     // Sum of scales plus carry from the multiply
        logic [MBITS-1:0]        fraction;  // MSB is the first bit after the hidden bit
    } posit_product_t;

    // Prepared encoding, handed from stage 2 to stage 3
    typedef struct packed {
        logic [2*NBITS-1:0] regime_exp_frac;  // Regime run, terminator, exponent, fraction
        logic [6:0]         regime_shift;     // Right shift that places the regime
        logic               after;            // First bit dropped by the shift
        logic               sticky;           // OR of every bit below it
    } posit_pack_t;

endpackage
